/* md5_pkg.sv */
// MD5 sizes, initial value, round constants, shift amounts, FSM encodings, byte swap
package md5_pkg;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------

	// Steps per 512-bit block
	localparam int STEPS = 64;
	// 128-bit loads per block
	localparam int WORDS_PER_BLOCK = 4;
	// Bytes per channel frame and per digest
	localparam int BYTES_PER_WORD = 16;

	localparam int LOAD_CNT_W = $clog2(WORDS_PER_BLOCK);
	localparam int BYTE_CNT_W = $clog2(BYTES_PER_WORD);

	// Terminal counts
	localparam logic [LOAD_CNT_W-1:0] LAST_LOAD = LOAD_CNT_W'(WORDS_PER_BLOCK - 1);
	localparam logic [BYTE_CNT_W-1:0] LAST_BYTE = BYTE_CNT_W'(BYTES_PER_WORD - 1);
	localparam logic [5:0] LAST_STEP = 6'(STEPS - 1);

	// ----------------------------------------------------------
	// Algorithm constants
	// ----------------------------------------------------------

	// Chaining start value, packed {D,C,B,A}
	localparam logic [127:0] IV = {32'h10325476, 32'h98badcfe, 32'hefcdab89, 32'h67452301};

	// Additive constants, one per step
	localparam logic [31:0] K [0:63] = '{
		32'hd76aa478, 32'he8c7b756, 32'h242070db, 32'hc1bdceee,
		32'hf57c0faf, 32'h4787c62a, 32'ha8304613, 32'hfd469501,
		32'h698098d8, 32'h8b44f7af, 32'hffff5bb1, 32'h895cd7be,
		32'h6b901122, 32'hfd987193, 32'ha679438e, 32'h49b40821,
		32'hf61e2562, 32'hc040b340, 32'h265e5a51, 32'he9b6c7aa,
		32'hd62f105d, 32'h02441453, 32'hd8a1e681, 32'he7d3fbc8,
		32'h21e1cde6, 32'hc33707d6, 32'hf4d50d87, 32'h455a14ed,
		32'ha9e3e905, 32'hfcefa3f8, 32'h676f02d9, 32'h8d2a4c8a,
		32'hfffa3942, 32'h8771f681, 32'h6d9d6122, 32'hfde5380c,
		32'ha4beea44, 32'h4bdecfa9, 32'hf6bb4b60, 32'hbebfbc70,
		32'h289b7ec6, 32'heaa127fa, 32'hd4ef3085, 32'h04881d05,
		32'hd9d4d039, 32'he6db99e5, 32'h1fa27cf8, 32'hc4ac5665,
		32'hf4292244, 32'h432aff97, 32'hab9423a7, 32'hfc93a039,
		32'h655b59c3, 32'h8f0ccc92, 32'hffeff47d, 32'h85845dd1,
		32'h6fa87e4f, 32'hfe2ce6e0, 32'ha3014314, 32'h4e0811a1,
		32'hf7537e82, 32'hbd3af235, 32'h2ad7d2bb, 32'heb86d391
	};

	// Left-rotate amounts, indexed {round, step[1:0]}
	localparam logic [4:0] S [0:15] = '{
		5'd7, 5'd12, 5'd17, 5'd22,
		5'd5, 5'd9,  5'd14, 5'd20,
		5'd4, 5'd11, 5'd16, 5'd23,
		5'd6, 5'd10, 5'd15, 5'd21
	};

	// ----------------------------------------------------------
	// Channel FSM encodings
	// ----------------------------------------------------------

	localparam logic [2:0] WR_IDLE  = 3'd0;
	localparam logic [2:0] WR_FIRST = 3'd1;
	localparam logic [2:0] WR_FILL  = 3'd2;
	localparam logic [2:0] WR_LOAD  = 3'd3;
	localparam logic [2:0] WR_WAIT  = 3'd4;

	localparam logic [1:0] RD_WAIT  = 2'd0;
	localparam logic [1:0] RD_FIRST = 2'd1;
	localparam logic [1:0] RD_READ  = 2'd2;

	// Reverse the four bytes of a word
	function automatic logic [31:0] swap32(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

endpackage

/* md5_step.sv */
// Single combinational MD5 step: round function, message word pick, add and rotate
`timescale 1ns/1ns

module md5_step (
	input  logic [31:0]  a_i,
	input  logic [31:0]  b_i,
	input  logic [31:0]  c_i,
	input  logic [31:0]  d_i,
	input  logic [511:0] block_i,
	input  logic [5:0]   step_i,
	output logic [31:0]  a_o,
	output logic [31:0]  b_o,
	output logic [31:0]  c_o,
	output logic [31:0]  d_o
);

	logic [1:0]  round;
	logic [3:0]  idx;
	logic [3:0]  g;
	logic [31:0] f;
	logic [31:0] m;
	logic [4:0]  s;
	logic [31:0] sum;
	logic [63:0] rot;

	// Round is the top two bits, position within round the rest
	assign round = step_i[5:4];
	assign idx = step_i[3:0];

	// ----------------------------------------------------------
	// Round function and message index schedule
	// ----------------------------------------------------------

	always_comb
	begin
		case (round)
			2'd0:
			begin
				// F
				f = (b_i & c_i) | (~b_i & d_i);
				g = idx;
			end
			2'd1:
			begin
				// G
				f = (d_i & b_i) | (~d_i & c_i);
				g = idx * 4'd5 + 4'd1;
			end
			2'd2:
			begin
				// H
				f = b_i ^ c_i ^ d_i;
				g = idx * 4'd3 + 4'd5;
			end
			default:
			begin
				// I
				f = c_i ^ (b_i | ~d_i);
				g = idx * 4'd7;
			end
		endcase
	end

	// Word 0 sits in the top bits of the block
	assign m = block_i[32 * (15 - g) +: 32];

	assign s = md5_pkg::S[{round, idx[1:0]}];
	assign sum = a_i + f + md5_pkg::K[step_i] + m;

	// Rotate left through a doubled word, upper half is the result
	assign rot = {sum, sum} << s;

	// Working set shifts round by one word
	assign a_o = d_i;
	assign b_o = b_i + rot[63:32];
	assign c_o = b_i;
	assign d_o = c_i;

endmodule

/* md5_core.sv */
// Iterative MD5 compression core: block assembly, step sequencing, chaining value
`timescale 1ns/1ns

module md5_core (
	input  logic         clk,
	input  logic         rst,
	input  logic         load_i,
	input  logic         newtext_i,
	input  logic [127:0] data_i,
	output logic         ready_o,
	output logic [127:0] data_o
);

	// Message block, first load ends up in the top bits
	logic [128*md5_pkg::WORDS_PER_BLOCK-1:0] block;
	logic [md5_pkg::LOAD_CNT_W-1:0] load_cnt;
	logic last_load;

	// Chaining value {D,C,B,A}
	logic [127:0] chain;
	logic [127:0] chain_sum;

	// Working registers
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	logic [31:0] a_nxt;
	logic [31:0] b_nxt;
	logic [31:0] c_nxt;
	logic [31:0] d_nxt;

	// Sequencing
	logic [5:0] step;
	logic busy;
	// Final add pending
	logic fold;

	// Fourth load of a block starts the run
	assign last_load = load_i && (load_cnt == md5_pkg::LAST_LOAD);

	// Per-word add of the working set into the chaining value
	assign chain_sum = {chain[127:96] + d, chain[95:64] + c, chain[63:32] + b, chain[31:0] + a};

	// ----------------------------------------------------------
	// Step logic
	// ----------------------------------------------------------

	md5_step step_unit (
		.a_i(a),
		.b_i(b),
		.c_i(c),
		.d_i(d),
		.block_i(block),
		.step_i(step),
		.a_o(a_nxt),
		.b_o(b_nxt),
		.c_o(c_nxt),
		.d_o(d_nxt)
	);

	// ----------------------------------------------------------
	// Control: load count, step counter, chaining value
	// ----------------------------------------------------------

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			load_cnt <= '0;
			step <= '0;
			busy <= 1'b0;
			fold <= 1'b0;
			ready_o <= 1'b0;
			chain <= md5_pkg::IV;
		end
		else
		begin
			ready_o <= 1'b0;

			// New message restarts from IV and block alignment
			if (newtext_i)
			begin
				chain <= md5_pkg::IV;
				load_cnt <= '0;
			end
			else if (load_i)
				load_cnt <= load_cnt + 1'b1;

			// 64 steps, one per cycle
			if (last_load)
			begin
				busy <= 1'b1;
				step <= '0;
			end
			else if (busy)
			begin
				step <= step + 1'b1;
				if (step == md5_pkg::LAST_STEP)
				begin
					busy <= 1'b0;
					fold <= 1'b1;
				end
			end

			// One more cycle for the chaining add
			if (fold)
			begin
				fold <= 1'b0;
				chain <= chain_sum;
				ready_o <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// Datapath registers
	// ----------------------------------------------------------

	always_ff @(posedge clk)
	begin
		if (load_i)
			block <= {block[128*(md5_pkg::WORDS_PER_BLOCK-1)-1:0], data_i};

		// Working set starts from the current chaining value
		if (last_load)
			{d, c, b, a} <= chain;
		else if (busy)
		begin
			a <= a_nxt;
			b <= b_nxt;
			c <= c_nxt;
			d <= d_nxt;
		end

		// Held until the next block finishes
		if (fold)
			data_o <= chain_sum;
	end

endmodule

/* port_md5.sv */
// Byte channel port around the MD5 core: write and read FSMs, shift registers, byte order
`timescale 1ns/1ns

module port_md5 (
	input  logic       clk,
	input  logic       rst,
	input  logic       wen_i,
	input  logic       ren_i,
	input  logic       in_sof_i,
	input  logic       in_src_rdy_i,
	output logic       in_dst_rdy_o,
	input  logic [7:0] in_data_i,
	output logic       out_sof_o,
	output logic       out_eof_o,
	input  logic       out_dst_rdy_i,
	output logic       out_src_rdy_o,
	output logic [7:0] out_data_o
);

	// Write side
	logic [2:0] wstate;
	logic [2:0] wstate_nxt;
	logic [md5_pkg::BYTE_CNT_W-1:0] wcount;
	logic [md5_pkg::LOAD_CNT_W-1:0] frame_cnt;
	logic in_byte_en;
	logic take_byte;
	logic [127:0] in_reg;

	// Read side
	logic [1:0] rstate;
	logic [1:0] rstate_nxt;
	logic [md5_pkg::BYTE_CNT_W-1:0] rcount;
	logic out_byte_en;
	logic give_byte;
	logic capture;
	logic [127:0] out_reg;
	logic [127:0] digest_bytes;

	// Core side
	logic core_load;
	logic core_newtext;
	logic core_ready;
	logic [127:0] core_data_in;
	logic [127:0] core_data_out;

	// ----------------------------------------------------------
	// Write FSM
	// ----------------------------------------------------------

	assign in_byte_en = wen_i & in_src_rdy_i;
	assign take_byte = in_byte_en & in_dst_rdy_o;

	// Only accept while a frame is open
	assign in_dst_rdy_o = (wstate == md5_pkg::WR_FIRST) || (wstate == md5_pkg::WR_FILL);
	assign core_load = (wstate == md5_pkg::WR_LOAD);

	// First byte is shown in idle, so sof is seen before it is taken
	assign core_newtext = (wstate == md5_pkg::WR_IDLE) & in_byte_en & in_sof_i & ~out_src_rdy_o;

	always_comb
	begin
		wstate_nxt = wstate;
		case (wstate)
			md5_pkg::WR_IDLE:
			begin
				// Hold off while a digest is undelivered
				if (in_byte_en && !out_src_rdy_o)
					wstate_nxt = md5_pkg::WR_FIRST;
			end
			md5_pkg::WR_FIRST:
			begin
				if (take_byte)
					wstate_nxt = md5_pkg::WR_FILL;
			end
			md5_pkg::WR_FILL:
			begin
				if (take_byte && wcount == md5_pkg::LAST_BYTE)
					wstate_nxt = md5_pkg::WR_LOAD;
			end
			md5_pkg::WR_LOAD:
			begin
				// Last frame of a block waits for the core
				if (frame_cnt == md5_pkg::LAST_LOAD)
					wstate_nxt = md5_pkg::WR_WAIT;
				else
					wstate_nxt = md5_pkg::WR_IDLE;
			end
			md5_pkg::WR_WAIT:
			begin
				if (core_ready)
					wstate_nxt = md5_pkg::WR_IDLE;
			end
			default:
				wstate_nxt = md5_pkg::WR_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wstate <= md5_pkg::WR_IDLE;
			wcount <= '0;
			frame_cnt <= '0;
		end
		else
		begin
			wstate <= wstate_nxt;
			// Wraps to zero after sixteen bytes
			if (take_byte)
				wcount <= wcount + 1'b1;
			if (core_newtext)
				frame_cnt <= '0;
			else if (core_load)
				frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// First byte ends up in the top byte
	always_ff @(posedge clk)
	begin
		if (take_byte)
			in_reg <= {in_reg[119:0], in_data_i};
	end

	// Each 32-bit word to little-endian, word 0 stays on top
	always_comb
	begin
		for (int i = 0; i < md5_pkg::BYTES_PER_WORD / 4; i++)
			core_data_in[32*i +: 32] = md5_pkg::swap32(in_reg[32*i +: 32]);
	end

	// ----------------------------------------------------------
	// Core
	// ----------------------------------------------------------

	md5_core core (
		.clk(clk),
		.rst(rst),
		.load_i(core_load),
		.newtext_i(core_newtext),
		.data_i(core_data_in),
		.ready_o(core_ready),
		.data_o(core_data_out)
	);

	// ----------------------------------------------------------
	// Read FSM
	// ----------------------------------------------------------

	assign out_byte_en = ren_i & out_dst_rdy_i;
	assign give_byte = out_byte_en & out_src_rdy_o;
	assign capture = core_ready && (rstate == md5_pkg::RD_WAIT);

	// Digest order: A first, low byte of each word first
	always_comb
	begin
		for (int i = 0; i < md5_pkg::BYTES_PER_WORD / 4; i++)
			digest_bytes[96-32*i +: 32] = md5_pkg::swap32(core_data_out[32*i +: 32]);
	end

	always_comb
	begin
		rstate_nxt = rstate;
		case (rstate)
			md5_pkg::RD_WAIT:
			begin
				if (core_ready)
					rstate_nxt = md5_pkg::RD_FIRST;
			end
			md5_pkg::RD_FIRST:
			begin
				if (give_byte)
					rstate_nxt = md5_pkg::RD_READ;
			end
			md5_pkg::RD_READ:
			begin
				if (give_byte && rcount == md5_pkg::LAST_BYTE)
					rstate_nxt = md5_pkg::RD_WAIT;
			end
			default:
				rstate_nxt = md5_pkg::RD_WAIT;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			rstate <= md5_pkg::RD_WAIT;
			rcount <= '0;
		end
		else
		begin
			rstate <= rstate_nxt;
			if (capture)
				rcount <= '0;
			else if (give_byte)
				rcount <= rcount + 1'b1;
		end
	end

	// Load on ready, then shift one byte per accepted read
	always_ff @(posedge clk)
	begin
		if (capture)
			out_reg <= digest_bytes;
		else if (give_byte)
			out_reg <= {out_reg[119:0], 8'h00};
	end

	// Frame flags from state and byte position
	assign out_src_rdy_o = (rstate != md5_pkg::RD_WAIT);
	assign out_sof_o = (rstate == md5_pkg::RD_FIRST);
	assign out_eof_o = (rstate == md5_pkg::RD_READ) && (rcount == md5_pkg::LAST_BYTE);
	assign out_data_o = out_reg[127:120];

endmodule

/* tb_clock.sv */
// Testbench clock source, 100 ns period
`timescale 1ns/1ns

module tb_clock (
	output logic clk_o
);

	// Half period in ns
	localparam int HALF_PERIOD = 50;

	initial
		clk_o = 1'b0;

	always #HALF_PERIOD clk_o = ~clk_o;

endmodule

/* md5_assertions.sv */
// Output channel and control output assertions, bound into port_md5
`timescale 1ns/1ns

module md5_assertions (
	input logic       clk_i,
	input logic       rst_i,
	input logic       ren_i,
	input logic       out_dst_rdy_i,
	input logic       out_src_rdy_i,
	input logic       out_sof_i,
	input logic       out_eof_i,
	input logic [7:0] out_data_i,
	input logic       in_dst_rdy_i
);

	// Frame flags only with a valid byte
	assert property (@(posedge clk_i) disable iff (rst_i)
		(out_sof_i || out_eof_i) |-> out_src_rdy_i)
		else $error("frame flag raised without out_src_rdy_o");

	// Offered byte holds until it is taken
	assert property (@(posedge clk_i) disable iff (rst_i)
		(out_src_rdy_i && !(ren_i && out_dst_rdy_i)) |=> $stable(out_data_i))
		else $error("output byte changed without a transfer");

	// Control outputs always known
	assert property (@(posedge clk_i) disable iff (rst_i)
		!$isunknown({in_dst_rdy_i, out_src_rdy_i, out_sof_i, out_eof_i}))
		else $error("unknown value on a control output");

endmodule

bind port_md5 md5_assertions protocol_chk (
	.clk_i(clk),
	.rst_i(rst),
	.ren_i(ren_i),
	.out_dst_rdy_i(out_dst_rdy_i),
	.out_src_rdy_i(out_src_rdy_o),
	.out_sof_i(out_sof_o),
	.out_eof_i(out_eof_o),
	.out_data_i(out_data_o),
	.in_dst_rdy_i(in_dst_rdy_o)
);

/* md5_ref.svh */
// Reference MD5 block compression and digest byte order for the testbench
`ifndef MD5_REF_SVH
`define MD5_REF_SVH

// ----------------------------------------------------------
// One compression from the MD5 definition
// ----------------------------------------------------------

// Chaining value {D,C,B,A}, message byte 0 in the top bits of blk
function automatic logic [127:0] md5_compress(input logic [127:0] chain,
		input logic [511:0] blk);
	logic [31:0] m [16];
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	logic [31:0] f;
	logic [31:0] t;
	int r;
	int g;
	int sh;
	// Sixteen little-endian message words
	for (int i = 0; i < 16; i++)
		m[i] = {blk[480 - 32*i +: 8], blk[488 - 32*i +: 8],
			blk[496 - 32*i +: 8], blk[504 - 32*i +: 8]};
	a = chain[31:0];
	b = chain[63:32];
	c = chain[95:64];
	d = chain[127:96];
	for (int i = 0; i < md5_pkg::STEPS; i++)
	begin
		r = i / 16;
		// Round function and word schedule per round
		if (r == 0)
		begin
			f = (b & c) | (~b & d);
			g = i;
		end
		else if (r == 1)
		begin
			f = (d & b) | (~d & c);
			g = (5 * i + 1) % 16;
		end
		else if (r == 2)
		begin
			f = b ^ c ^ d;
			g = (3 * i + 5) % 16;
		end
		else
		begin
			f = c ^ (b | ~d);
			g = (7 * i) % 16;
		end
		sh = int'(md5_pkg::S[4 * r + i % 4]);
		t = a + f + md5_pkg::K[i] + m[g];
		t = (t << sh) | (t >> (32 - sh));
		a = d;
		d = c;
		c = b;
		b = b + t;
	end
	return {chain[127:96] + d, chain[95:64] + c, chain[63:32] + b, chain[31:0] + a};
endfunction

// Byte k of the digest, low byte of A first
function automatic logic [7:0] digest_byte(input logic [127:0] chain, input int k);
	return chain[32 * (k / 4) + 8 * (k % 4) +: 8];
endfunction

`endif

/* md5_tb.sv */
// Testbench top with reset, byte stimulus, xorshift, check task and output compare
`timescale 1ns/1ns

module md5_tb;

	localparam logic [31:0] SEED = 32'he0d4_9883;
	localparam int BYTE_LIMIT = 2000;
	localparam int DRAIN_LIMIT = 4000;
	localparam int VALID_LIMIT = 200;

	logic       clk;
	logic       rst;
	logic       wen_i;
	logic       ren_i;
	logic       in_sof_i;
	logic       in_src_rdy_i;
	logic       in_dst_rdy_o;
	logic [7:0] in_data_i;
	logic       out_sof_o;
	logic       out_eof_o;
	logic       out_dst_rdy_i;
	logic       out_src_rdy_o;
	logic [7:0] out_data_o;

	// Stimulus control shared by the driving processes
	logic [31:0] rng = SEED;
	logic [31:0] rng_out = SEED;
	logic        stall_in = 1'b0;
	logic        stall_out = 1'b0;
	logic        hold_read = 1'b0;
	string       test_name = "reset";

	// Padded message bytes and expected output bytes
	logic [7:0] message [$];
	logic [7:0] expected [$];

	`include "md5_ref.svh"

	tb_clock clkgen (
		.clk_o(clk)
	);

	port_md5 dut (
		.clk(clk),
		.rst(rst),
		.wen_i(wen_i),
		.ren_i(ren_i),
		.in_sof_i(in_sof_i),
		.in_src_rdy_i(in_src_rdy_i),
		.in_dst_rdy_o(in_dst_rdy_o),
		.in_data_i(in_data_i),
		.out_sof_o(out_sof_o),
		.out_eof_o(out_eof_o),
		.out_dst_rdy_i(out_dst_rdy_i),
		.out_src_rdy_o(out_src_rdy_o),
		.out_data_o(out_data_o)
	);

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run(input string why);
		$display("Some tests failed");
		$fatal(1, "%s", why);
	endtask

	task automatic compare_value(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
			fail_run("value mismatch");
		end
	endtask

	// Random payload followed by 0x80, zeros and the bit length
	task automatic make_message(input int len);
		logic [63:0] bit_len;
		message.delete();
		for (int i = 0; i < len; i++)
		begin
			rng = xorshift32(rng);
			message.push_back(rng[7:0]);
		end
		bit_len = 64'(message.size()) * 64'd8;
		message.push_back(8'h80);
		while (message.size() % 64 != 56)
			message.push_back(8'h00);
		for (int i = 0; i < 8; i++)
			message.push_back(bit_len[8*i +: 8]);
	endtask

	function automatic logic [511:0] block_of(input int b);
		logic [511:0] blk;
		for (int j = 0; j < 64; j++)
			blk[504 - 8*j +: 8] = message[64*b + j];
		return blk;
	endfunction

	// Present one byte from a falling edge until the DUT takes it
	task automatic send_byte(input logic [7:0] value, input logic sof);
		int cycles;
		logic taken;
		cycles = 0;
		taken = 1'b0;
		in_data_i = value;
		in_sof_i = sof;
		while (!taken)
		begin
			if (stall_in)
			begin
				rng = xorshift32(rng);
				wen_i = rng[0] | rng[1];
				in_src_rdy_i = rng[2] | rng[3];
			end
			else
			begin
				wen_i = 1'b1;
				in_src_rdy_i = 1'b1;
			end
			// Ready only moves on the rising edge
			taken = wen_i & in_src_rdy_i & in_dst_rdy_o;
			@(negedge clk);
			cycles++;
			if (cycles > BYTE_LIMIT)
				fail_run("timeout waiting for the DUT to take an input byte");
		end
		wen_i = 1'b0;
		in_src_rdy_i = 1'b0;
		in_sof_i = 1'b0;
	endtask

	// Whole padded message from IV with one expected digest per block
	task automatic send_message();
		logic [127:0] chain;
		chain = md5_pkg::IV;
		for (int b = 0; b < message.size() / 64; b++)
		begin
			chain = md5_compress(chain, block_of(b));
			for (int k = 0; k < md5_pkg::BYTES_PER_WORD; k++)
				expected.push_back(digest_byte(chain, k));
			for (int j = 0; j < 64; j++)
				send_byte(message[64*b + j], (b == 0) && (j == 0));
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (expected.size() != 0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > DRAIN_LIMIT)
				fail_run("timeout waiting for digest bytes on the output");
		end
	endtask

	task automatic wait_output_valid();
		int cycles;
		cycles = 0;
		while (!out_src_rdy_o)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > VALID_LIMIT)
				fail_run("timeout waiting for the DUT to offer a digest");
		end
	endtask

	// ----------------------------------------------------------
	// Output side drive and compare
	// ----------------------------------------------------------

	initial
	begin
		ren_i = 1'b0;
		out_dst_rdy_i = 1'b0;
		forever
		begin
			@(negedge clk);
			if (hold_read)
			begin
				ren_i = 1'b0;
				out_dst_rdy_i = 1'b1;
			end
			else if (stall_out)
			begin
				rng_out = xorshift32(rng_out);
				ren_i = rng_out[0] | rng_out[1];
				out_dst_rdy_i = rng_out[2] | rng_out[3];
			end
			else
			begin
				ren_i = 1'b1;
				out_dst_rdy_i = 1'b1;
			end
		end
	end

	// Sampled on the rising edge before the DUT updates
	initial
	begin
		int out_index;
		logic [7:0] exp_byte;
		out_index = 0;
		forever
		begin
			@(posedge clk);
			if (!rst)
			begin
				// No input while a digest waits
				compare_value("input refused while digest pending", 32'd0,
					32'(in_dst_rdy_o & out_src_rdy_o));
				if (out_src_rdy_o && ren_i && out_dst_rdy_i)
				begin
					if (expected.size() == 0)
						fail_run("output byte arrived with no digest expected");
					exp_byte = expected.pop_front();
					compare_value(test_name, 32'(exp_byte), 32'(out_data_o));
					compare_value({test_name, " sof"}, 32'(out_index == 0), 32'(out_sof_o));
					compare_value({test_name, " eof"},
						32'(out_index == md5_pkg::BYTES_PER_WORD - 1), 32'(out_eof_o));
					out_index = (out_index + 1) % md5_pkg::BYTES_PER_WORD;
				end
			end
		end
	end

	// ----------------------------------------------------------
	// Tests
	// ----------------------------------------------------------

	initial
	begin
		logic [127:0] abc_digest;
		logic [127:0] known;
		known = 128'h900150983cd24fb0d6963f7d28e17f72;
		rst = 1'b1;
		wen_i = 1'b0;
		in_sof_i = 1'b0;
		in_src_rdy_i = 1'b0;
		in_data_i = 8'h00;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Channel idle after reset
		@(negedge clk);
		compare_value("reset in_dst_rdy_o", 32'd0, 32'(in_dst_rdy_o));
		compare_value("reset out_src_rdy_o", 32'd0, 32'(out_src_rdy_o));
		compare_value("reset out_sof_o", 32'd0, 32'(out_sof_o));
		compare_value("reset out_eof_o", 32'd0, 32'(out_eof_o));

		// One-block "abc" against the published digest
		test_name = "abc digest";
		message = '{8'h61, 8'h62, 8'h63, 8'h80};
		while (message.size() < 56)
			message.push_back(8'h00);
		message.push_back(8'h18);
		repeat (7) message.push_back(8'h00);
		abc_digest = md5_compress(md5_pkg::IV, block_of(0));
		for (int k = 0; k < 16; k++)
			compare_value("abc reference", 32'(known[120 - 8*k +: 8]),
				32'(digest_byte(abc_digest, k)));
		send_message();
		wait_drained();

		// Three blocks give three output frames
		test_name = "multi-block";
		make_message(120 + int'(rng[5:0]));
		send_message();
		wait_drained();

		// Fresh start from IV
		test_name = "new message";
		make_message(int'(rng[5:0]) % 56);
		send_message();
		wait_drained();

		// Random gaps on both channels
		test_name = "stalls";
		stall_in = 1'b1;
		stall_out = 1'b1;
		make_message(56 + int'(rng[5:0]));
		send_message();
		wait_drained();
		// Next digest stays undelivered while ren_i is low
		make_message(int'(rng[5:0]) % 56);
		hold_read = 1'b1;
		send_message();
		wait_output_valid();
		make_message(120 + int'(rng[5:0]));
		fork
			send_message();
			begin
				repeat (20)
				begin
					@(negedge clk);
					compare_value("stalls input refused", 32'd0, 32'(in_dst_rdy_o));
					compare_value("stalls digest held", 32'd1, 32'(out_src_rdy_o));
				end
				hold_read = 1'b0;
			end
		join
		wait_drained();

		$display("All tests passed");
		$finish;
	end

endmodule

/* project.f */
+incdir+.
md5_pkg.sv
md5_step.sv
md5_core.sv
port_md5.sv
tb_clock.sv
md5_assertions.sv
md5_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := md5_tb
FILELIST := project.f
OBJ_DIR := obj_dir
VFLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
